/* src/rc_settings.svh */
/*
 * Global sizes for the row connection unit.
 * Included by the packages and by any module that needs a count or a
 * source window. Definitions only.
 */

`ifndef RC_SETTINGS_SVH
`define RC_SETTINGS_SVH

// Data path
`define RC_DWORD_BITS     32
`define RC_PE_NUM         4
`define RC_SRC_PER_PE     12
`define RC_SRC_NUM        48   // RC_PE_NUM * RC_SRC_PER_PE

// Context memory and unit decode
`define RC_CTX_ADDR_BITS  5    // 32 context entries
`define RC_UNIT_BITS      2
`define RC_CTX_BITS       52   // 4 x (6 + 4 + 3)

// Selector windows
`define RC_B16_BASE       12
`define RC_B16_WAYS       16
`define RC_B8_BASE        16
`define RC_B8_WAYS        8
`define RC_LANES          4    // Lanes per selector class

`endif

/* src/rc_data_pkg.sv */
/*
 * Data side types of the row connection unit.
 * Source words from the four processing elements travel as one packed
 * vector; index = element * 12 + group * 4 + position.
 */

`include "rc_settings.svh"

package rc_data_pkg;

	// One data word from a PE output
	typedef logic [`RC_DWORD_BITS-1:0] dword_t;

	// All PE outputs seen by the row
	// Group 0 ALU, group 1 16-way buffer, group 2 8-way buffer
	typedef dword_t [`RC_SRC_NUM-1:0] src_vec_t;

	// Four routed lanes of one selector class
	typedef dword_t [`RC_LANES-1:0] route_vec_t;

endpackage

/* src/rc_ctx_pkg.sv */
/*
 * Context side types of the row connection unit.
 * Holds the Wishbone address split, the context address and the layout
 * of one 52-bit context word as loaded by the host.
 */

`include "rc_settings.svh"

package rc_ctx_pkg;

	typedef logic [`RC_CTX_ADDR_BITS-1:0] ctx_addr_t;
	typedef logic [`RC_UNIT_BITS-1:0]     unit_t;

	// Unit number in the upper bits, context entry below
	typedef struct packed {
		unit_t     unit;
		ctx_addr_t addr;
	} wb_adr_t;

	// Lane select fields
	typedef logic [$clog2(`RC_SRC_NUM)-1:0]  alu_sel_t;  // 6 bits, 48..63 unused
	typedef logic [$clog2(`RC_B16_WAYS)-1:0] b16_sel_t;
	typedef logic [$clog2(`RC_B8_WAYS)-1:0]  b8_sel_t;

	// One context word, MSB first
	// Lane 0 sits at the top of each group
	typedef struct packed {
		alu_sel_t [0:`RC_LANES-1] alu_sel;  // Bits 51:28
		b16_sel_t [0:`RC_LANES-1] b16_sel;  // Bits 27:12
		b8_sel_t  [0:`RC_LANES-1] b8_sel;   // Bits 11:0
	} ctx_word_t;

endpackage

/* src/ctx_loader.sv */
/*
 * Wishbone classic write slave for the context memory.
 * Accepts cycles whose unit field matches UNIT_NO, answers with a one
 * cycle ack, and forwards writes to the context RAM. The last written
 * address becomes the end address of the next run.
 */

`timescale 1ns/1ps

module ctx_loader
	import rc_ctx_pkg::*;
#(
	parameter int UNIT_NO = 0
) (
	input  logic      CLK,
	input  logic      RST,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  wb_adr_t   wb_adr,
	input  ctx_word_t wb_dat,
	output logic      wb_ack,
	output logic      wr_en,
	output ctx_addr_t wr_addr,
	output ctx_word_t wr_data,
	output ctx_addr_t end_addr
);

	logic unit_hit;
	logic accept;    // New request, not yet answered
	logic wr_accept;

	assign unit_hit  = (wb_adr.unit == unit_t'(UNIT_NO));
	assign accept    = wb_cyc && wb_stb && unit_hit && !wb_ack;
	assign wr_accept = accept && wb_we;

	// Ack and write strobe rise together, one cycle after the request
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			wb_ack   <= 1'b0;
			wr_en    <= 1'b0;
			end_addr <= '0;
		end else begin
			wb_ack <= accept;
			wr_en  <= wr_accept;
			if (wr_accept)
				end_addr <= wb_adr.addr;  // Last write marks end of run
		end
	end

	// Write payload, qualified by wr_en
	always_ff @(posedge CLK) begin
		if (wr_accept) begin
			wr_addr <= wb_adr.addr;
			wr_data <= wb_dat;
		end
	end

endmodule

/* src/ctx_ram.sv */
/*
 * Context memory, 32 words of 52 bits.
 * One write port from the loader and one registered read port for the
 * sequencer. Read data holds while rd_en is low.
 */

`timescale 1ns/1ps

module ctx_ram
	import rc_ctx_pkg::*;
(
	input  logic      CLK,
	input  logic      wr_en,
	input  ctx_addr_t wr_addr,
	input  ctx_word_t wr_data,
	input  logic      rd_en,
	input  ctx_addr_t rd_addr,
	output ctx_word_t rd_data
);

	localparam int DEPTH = 1 << $bits(ctx_addr_t);

	ctx_word_t mem [0:DEPTH-1];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];  // Held otherwise
	end

endmodule

/* src/ctx_sequencer.sv */
/*
 * Run control for the context memory read side.
 * A start pulse in idle begins a run at address 0; step advances the
 * address and a step on the end address closes the run. data_valid
 * follows rd_en by one cycle to line up with the RAM read data.
 */

`timescale 1ns/1ps

module ctx_sequencer
	import rc_ctx_pkg::*;
(
	input  logic      CLK,
	input  logic      RST,
	input  logic      start,
	input  logic      step,
	input  ctx_addr_t end_addr,
	output logic      busy,
	output logic      rd_en,
	output ctx_addr_t rd_addr,
	output logic      data_valid
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_t;

	state_t state;
	logic   last_step;

	assign busy  = (state == ST_RUN);
	assign rd_en = busy;  // Read every cycle of a run

	// Final address consumed this cycle
	assign last_step = busy && step && (rd_addr == end_addr);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state   <= ST_IDLE;
			rd_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					rd_addr <= '0;
					if (start)
						state <= ST_RUN;
				end
				ST_RUN: begin
					if (step)
						rd_addr <= rd_addr + 1'b1;
					if (last_step) begin
						state   <= ST_IDLE;
						rd_addr <= '0;
					end
				end
				default: begin
					state   <= ST_IDLE;
					rd_addr <= '0;
				end
			endcase
		end
	end

	// Read data is valid the cycle after the read
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST)
			data_valid <= 1'b0;
		else
			data_valid <= rd_en;
	end

endmodule

/* src/lane_mux.sv */
/*
 * One output lane selector over a window of the source vector.
 * Picks source BASE + sel for sel below WIDTH, zero otherwise.
 */

`timescale 1ns/1ps
`include "rc_settings.svh"

module lane_mux
	import rc_data_pkg::*;
	import rc_ctx_pkg::*;
#(
	parameter int BASE  = 0,
	parameter int WIDTH = `RC_SRC_NUM
) (
	input  src_vec_t src,
	input  alu_sel_t sel,
	output dword_t   y
);

	always_comb begin
		y = '0;  // Out of window selects
		for (int i = 0; i < WIDTH; i++) begin
			if (sel == alu_sel_t'(i))
				y = src[BASE + i];
		end
	end

endmodule

/* src/route_output.sv */
/*
 * Output side of the row connection unit.
 * Twelve lane selectors driven by the current context word, followed
 * by the output registers. Outputs are zero whenever route_valid is low.
 */

`timescale 1ns/1ps
`include "rc_settings.svh"

module route_output
	import rc_data_pkg::*;
	import rc_ctx_pkg::*;
(
	input  logic       CLK,
	input  logic       RST,
	input  src_vec_t   src,
	input  ctx_word_t  ctx,
	input  logic       data_valid,
	output route_vec_t alu_route,
	output route_vec_t b16_route,
	output route_vec_t b8_route,
	output logic       route_valid
);

	route_vec_t alu_mux;
	route_vec_t b16_mux;
	route_vec_t b8_mux;

	for (genvar i = 0; i < `RC_LANES; i++) begin : g_lane
		// ALU route sees every PE output
		lane_mux #(
			.BASE  (0),
			.WIDTH (`RC_SRC_NUM)
		) u_alu (
			.src (src),
			.sel (ctx.alu_sel[i]),
			.y   (alu_mux[i])
		);

		lane_mux #(
			.BASE  (`RC_B16_BASE),
			.WIDTH (`RC_B16_WAYS)
		) u_b16 (
			.src (src),
			.sel (alu_sel_t'(ctx.b16_sel[i])),  // Zero extended
			.y   (b16_mux[i])
		);

		lane_mux #(
			.BASE  (`RC_B8_BASE),
			.WIDTH (`RC_B8_WAYS)
		) u_b8 (
			.src (src),
			.sel (alu_sel_t'(ctx.b8_sel[i])),
			.y   (b8_mux[i])
		);
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			alu_route   <= '0;
			b16_route   <= '0;
			b8_route    <= '0;
			route_valid <= 1'b0;
		end else begin
			route_valid <= data_valid;
			if (data_valid) begin
				alu_route <= alu_mux;
				b16_route <= b16_mux;
				b8_route  <= b8_mux;
			end else begin
				// Idle cycles carry no data
				alu_route <= '0;
				b16_route <= '0;
				b8_route  <= '0;
			end
		end
	end

endmodule

/* src/row_connection.sv */
/*
 * Row connection unit of the reconfigurable array.
 * The host loads routing contexts over Wishbone; a start pulse then
 * replays them, one per step, onto twelve registered output lanes.
 */

`timescale 1ns/1ps

module row_connection
	import rc_data_pkg::*;
	import rc_ctx_pkg::*;
#(
	parameter int UNIT_NO = 0
) (
	input  logic       CLK,
	input  logic       RST,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_adr_t    wb_adr,
	input  ctx_word_t  wb_dat,
	output logic       wb_ack,
	input  logic       start,
	input  logic       step,
	input  src_vec_t   src,
	output logic       busy,
	output route_vec_t alu_route,
	output route_vec_t b16_route,
	output route_vec_t b8_route,
	output logic       route_valid
);

	logic      wr_en;
	ctx_addr_t wr_addr;
	ctx_word_t wr_data;
	ctx_addr_t end_addr;
	logic      rd_en;
	ctx_addr_t rd_addr;
	ctx_word_t rd_data;
	logic      data_valid;

	ctx_loader #(
		.UNIT_NO (UNIT_NO)
	) u_loader (
		.CLK      (CLK),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat   (wb_dat),
		.wb_ack   (wb_ack),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.end_addr (end_addr)
	);

	ctx_ram u_ram (
		.CLK     (CLK),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Read address in cycle t, routed data out in cycle t+2
	ctx_sequencer u_seq (
		.CLK        (CLK),
		.RST        (RST),
		.start      (start),
		.step       (step),
		.end_addr   (end_addr),
		.busy       (busy),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.data_valid (data_valid)
	);

	route_output u_route (
		.CLK         (CLK),
		.RST         (RST),
		.src         (src),
		.ctx         (rd_data),
		.data_valid  (data_valid),
		.alu_route   (alu_route),
		.b16_route   (b16_route),
		.b8_route    (b8_route),
		.route_valid (route_valid)
	);

endmodule

/* tb/tb_clock.sv */
/*
 * Clock and reset source for the testbench.
 * Free-running 4 ns clock; RST is held low for the first RST_CYCLES edges.
 */

`timescale 1ns/1ps

module tb_clock #(
	parameter int RST_CYCLES = 16
) (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;  // 4 ns period
	end

	initial begin
		RST = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		RST <= 1'b1;  // Released on a rising edge
	end

endmodule

/* tb/tb_row_connection.sv */
/*
 * Testbench for the row connection unit.
 * Loads contexts over Wishbone, replays them with steady and random step,
 * and checks busy, route_valid and all twelve lanes every cycle against a
 * reference model of the context run.
 */

`timescale 1ns/1ps
`include "rc_settings.svh"

module tb_row_connection
	import rc_data_pkg::*;
	import rc_ctx_pkg::*;
();

	localparam int UNIT_NO   = 1;
	localparam int RUN_LIMIT = 400;  // Cycles allowed for one run

	logic       CLK;
	logic       RST;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	wb_adr_t    wb_adr;
	ctx_word_t  wb_dat;
	logic       wb_ack;
	logic       start;
	logic       step;
	src_vec_t   src;
	logic       busy;
	route_vec_t alu_route;
	route_vec_t b16_route;
	route_vec_t b8_route;
	logic       route_valid;

	// Reference model state
	ctx_word_t  ref_ctx [0:31];
	ctx_addr_t  ref_end = '0;
	logic       ref_busy;
	ctx_addr_t  ref_addr;
	logic       valid_d1;
	ctx_addr_t  addr_d1;
	logic       exp_valid;
	ctx_word_t  exp_ctx;
	route_vec_t exp_alu;
	route_vec_t exp_b16;
	route_vec_t exp_b8;

	int         cycle_errors = 0;  // From the per-cycle assertions
	int         task_errors  = 0;  // From the sequence checks
	string      test_name = "reset";

	tb_clock u_clock (
		.CLK (CLK),
		.RST (RST)
	);

	row_connection #(
		.UNIT_NO (UNIT_NO)
	) UUT (
		.CLK         (CLK),
		.RST         (RST),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat      (wb_dat),
		.wb_ack      (wb_ack),
		.start       (start),
		.step        (step),
		.src         (src),
		.busy        (busy),
		.alu_route   (alu_route),
		.b16_route   (b16_route),
		.b8_route    (b8_route),
		.route_valid (route_valid)
	);

	// Address tracker, then two cycles to the outputs
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			ref_busy  <= 1'b0;
			ref_addr  <= '0;
			valid_d1  <= 1'b0;
			addr_d1   <= '0;
			exp_valid <= 1'b0;
		end else begin
			if (!ref_busy) begin
				ref_addr <= '0;
				ref_busy <= start;
			end else if (step) begin
				ref_addr <= ref_addr + 1'b1;
				if (ref_addr == ref_end)
					ref_busy <= 1'b0;  // End address consumed
			end
			valid_d1  <= ref_busy;
			addr_d1   <= ref_addr;
			exp_valid <= valid_d1;
			exp_ctx   <= ref_ctx[addr_d1];
		end
	end

	// Expected lanes from the select windows
	always_comb begin
		for (int i = 0; i < `RC_LANES; i++) begin
			exp_alu[i] = '0;
			exp_b16[i] = '0;
			exp_b8[i]  = '0;
			if (exp_valid) begin
				if (exp_ctx.alu_sel[i] < `RC_SRC_NUM)
					exp_alu[i] = src[exp_ctx.alu_sel[i]];  // 48 and up stay zero
				exp_b16[i] = src[alu_sel_t'(`RC_B16_BASE + exp_ctx.b16_sel[i])];
				exp_b8[i]  = src[alu_sel_t'(`RC_B8_BASE + exp_ctx.b8_sel[i])];
			end
		end
	end

	task automatic show_mismatch(input string what, input dword_t expected,
			input dword_t actual);
		$display("mismatch %s %s: expected %h, actual %h",
			test_name, what, expected, actual);
	endtask

	assert property (@(negedge CLK) busy == ref_busy)
		else begin
			cycle_errors++;
			show_mismatch("busy", dword_t'(ref_busy), dword_t'(busy));
		end

	assert property (@(negedge CLK) route_valid == exp_valid)
		else begin
			cycle_errors++;
			show_mismatch("route_valid", dword_t'(exp_valid),
				dword_t'(route_valid));
		end

	for (genvar i = 0; i < `RC_LANES; i++) begin : g_lane_check
		assert property (@(negedge CLK) alu_route[i] == exp_alu[i])
			else begin
				cycle_errors++;
				show_mismatch($sformatf("alu_route[%0d]", i), exp_alu[i],
					alu_route[i]);
			end
		assert property (@(negedge CLK) b16_route[i] == exp_b16[i])
			else begin
				cycle_errors++;
				show_mismatch($sformatf("b16_route[%0d]", i), exp_b16[i],
					b16_route[i]);
			end
		assert property (@(negedge CLK) b8_route[i] == exp_b8[i])
			else begin
				cycle_errors++;
				show_mismatch($sformatf("b8_route[%0d]", i), exp_b8[i],
					b8_route[i]);
			end
	end

	function automatic ctx_word_t rand_ctx();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[`RC_CTX_BITS-1:0];
	endfunction

	// One Wishbone classic write; only our own unit may answer
	task automatic wb_write(input unit_t unit, input ctx_addr_t addr, input ctx_word_t data);
		int n;
		int limit;
		logic hit;
		logic acked;
		hit   = (unit == unit_t'(UNIT_NO));
		limit = hit ? 4 : 8;
		n     = 0;
		acked = 1'b0;
		@(posedge CLK);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b1;
		wb_adr <= {unit, addr};
		wb_dat <= data;
		while (!acked && n < limit) begin
			@(negedge CLK);
			acked = wb_ack;
			n++;
		end
		@(posedge CLK);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		if (hit) begin
			assert (acked) else begin
				task_errors++;
				$display("write to unit %0d address %0d got no ack within 4 cycles",
					unit, addr);
			end
			ref_ctx[addr] = data;
			ref_end       = addr;
		end else begin
			assert (!acked) else begin
				task_errors++;
				$display("write to foreign unit %0d was acknowledged", unit);
			end
		end
	endtask

	task automatic load_contexts(input int last, input logic wide_sels);
		ctx_word_t c;
		for (int a = 0; a <= last; a++) begin
			c = rand_ctx();
			if (a == 0 && wide_sels) begin
				c.alu_sel[0] = 6'd63;  // Outside the 48 sources
				c.alu_sel[1] = 6'd48;
				c.alu_sel[2] = 6'd47;
			end
			wb_write(unit_t'(UNIT_NO), ctx_addr_t'(a), c);
		end
	endtask

	task automatic new_sources();
		@(posedge CLK);
		for (int i = 0; i < `RC_SRC_NUM; i++)
			src[i] <= $urandom;
	endtask

	// Start a run and count busy, route_valid and held cycles until idle
	task automatic run_contexts(input logic random_step);
		int n;
		int holds;
		int busy_cycles;
		int valid_cycles;
		int expect_len;
		logic seen;
		logic done;
		n            = 0;
		holds        = 0;
		busy_cycles  = 0;
		valid_cycles = 0;
		seen         = 1'b0;
		done         = 1'b0;
		expect_len   = int'(ref_end) + 1;
		@(posedge CLK);
		start <= 1'b1;
		step  <= 1'b1;
		while (!done && n < RUN_LIMIT) begin
			@(negedge CLK);
			if (busy) begin
				seen = 1'b1;
				busy_cycles++;
			end
			if (route_valid)
				valid_cycles++;
			done = seen && !busy && !route_valid;
			@(posedge CLK);
			if (ref_busy && !step)
				holds++;  // Held cycle lengthens the run
			start <= 1'b0;
			if (random_step)
				step <= ($urandom_range(0, 3) != 0);
			n++;
		end
		step <= 1'b1;
		if (!done) begin
			task_errors++;
			$display("run in test %s did not finish within %0d cycles",
				test_name, RUN_LIMIT);
		end
		assert (busy_cycles == expect_len + holds) else begin
			task_errors++;
			show_mismatch("busy cycles", dword_t'(expect_len + holds),
				dword_t'(busy_cycles));
		end
		assert (valid_cycles == expect_len + holds) else begin
			task_errors++;
			show_mismatch("valid cycles", dword_t'(expect_len + holds),
				dword_t'(valid_cycles));
		end
	endtask

	initial begin
		int n;
		void'($urandom(11));
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		start  = 1'b0;
		step   = 1'b1;
		src    = '0;
		n      = 0;
		while (!RST && n < 64) begin
			@(posedge CLK);
			n++;
		end
		if (!RST) begin
			task_errors++;
			$display("reset was not released within 64 cycles");
		end
		repeat (4) @(posedge CLK);  // Idle outputs checked meanwhile

		test_name = "load_and_route";
		load_contexts(7, 1'b1);
		new_sources();
		run_contexts(1'b0);

		test_name = "foreign_unit";
		wb_write(2'd2, 5'd31, rand_ctx());
		wb_write(2'd2, 5'd0, rand_ctx());
		new_sources();
		run_contexts(1'b0);

		test_name = "back_pressure";
		load_contexts(11, 1'b0);
		new_sources();
		run_contexts(1'b1);

		test_name = "full_depth";
		load_contexts(31, 1'b1);
		new_sources();
		run_contexts(1'b1);

		repeat (4) @(posedge CLK);
		$display("errors: cycle checks %0d, sequence checks %0d",
			cycle_errors, task_errors);
		if (cycle_errors == 0 && task_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* sim.f */
+incdir+src
src/rc_data_pkg.sv
src/rc_ctx_pkg.sv
src/ctx_loader.sv
src/ctx_ram.sv
src/ctx_sequencer.sv
src/lane_mux.sv
src/route_output.sv
src/row_connection.sv
tb/tb_clock.sv
tb/tb_row_connection.sv

/* run.sh */
#!/bin/sh
# Build and run the row connection testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module tb_row_connection -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
